//--- filelist.f
+incdir+verification
verilog/gpio_bus_pkg.sv
verilog/bus_access_ctrl.sv
verilog/gpo_reg_bank.sv
verilog/gpio_bus_slave.sv
verification/gpio_bus_tb.sv

//--- verification/gpio_bus_model.svh
// reference model for the gpio bus slave testbench
// keeps its own copy of the gpo bank and predicts each response from the map
// also holds the typed compare tasks and the check counters
// included inside the testbench module

`ifndef gpio_bus_model_svh
`define gpio_bus_model_svh

	////////////////////////////////////////////////////////////////////////////
	// model state
	////////////////////////////////////////////////////////////////////////////

	// expected output words, zero after reset
	gpio_bus_pkg::gpio_bank_u model_bank;
	// last good read data, unknown until the first one
	logic [gpio_bus_pkg::data_w-1:0] model_rd;

	int checks_run;
	int checks_failed;

	// apply one request to the model, gives response and strobe for the ready cycle
	task automatic predict(input gpio_bus_pkg::bus_req_t r,
		input gpio_bus_pkg::gpio_bank_u ip,
		output gpio_bus_pkg::bus_rsp_t exp_rsp,
		output logic [gpio_bus_pkg::gpio_words-1:0] exp_strobe);
		bit in_gpo;
		bit in_gpi;
		bit bad;
		int unsigned w;
		// each range is gpio_words words of four bytes
		in_gpo = r.addr >= gpio_bus_pkg::gpo_base &&
			r.addr < gpio_bus_pkg::gpo_base + gpio_bus_pkg::gpio_words * 4;
		in_gpi = r.addr >= gpio_bus_pkg::gpi_base &&
			r.addr < gpio_bus_pkg::gpi_base + gpio_bus_pkg::gpio_words * 4;
		bad = !(in_gpo || in_gpi) || (r.addr % 4 != 0) || (in_gpi && !r.rnw);
		if (in_gpi)
			w = (r.addr - gpio_bus_pkg::gpi_base) / 4;
		else
			w = (r.addr - gpio_bus_pkg::gpo_base) / 4;
		exp_strobe = '0;
		if (!bad && r.rnw) begin
			model_rd = in_gpi ? ip.words[w] : model_bank.words[w];
		end else if (!bad) begin
			// good gpo write, one word and its strobe
			model_bank.words[w] = r.write_data;
			exp_strobe[w] = 1'b1;
		end
		// read data holds unless a good read replaced it
		exp_rsp.read_data = model_rd;
		exp_rsp.error = bad;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare tasks, one per kind of result
	////////////////////////////////////////////////////////////////////////////

	task automatic check_rsp(input string name, input gpio_bus_pkg::bus_rsp_t exp,
		input gpio_bus_pkg::bus_rsp_t act);
		checks_run++;
		if (exp !== act) begin
			checks_failed++;
			$display("FAIL %s rsp expected data %h error %b actual data %h error %b",
				name, exp.read_data, exp.error, act.read_data, act.error);
		end
	endtask

	task automatic check_bank(input string name, input gpio_bus_pkg::gpio_bank_u exp,
		input gpio_bus_pkg::gpio_bank_u act);
		checks_run++;
		if (exp !== act) begin
			checks_failed++;
			$display("FAIL %s gp_op expected %h actual %h", name, exp.flat, act.flat);
		end
	endtask

	task automatic check_strobe(input string name,
		input logic [gpio_bus_pkg::gpio_words-1:0] exp,
		input logic [gpio_bus_pkg::gpio_words-1:0] act);
		checks_run++;
		if (exp !== act) begin
			checks_failed++;
			$display("FAIL %s gp_op_valid expected %b actual %b", name, exp, act);
		end
	endtask

	// latency in edges, acceptance edge counted
	task automatic check_latency(input string name, input int exp, input int act);
		checks_run++;
		if (exp != act) begin
			checks_failed++;
			$display("FAIL %s latency expected %0d actual %0d", name, exp, act);
		end
	endtask

`endif

//--- verification/gpio_bus_tb.sv
// testbench for the gpio bus slave
// random requests over gpo, gpi, outside and unaligned addresses from a fixed seed,
// each checked against the model for response, pins, strobes and latency
// prints one line per test and a closing count line

`timescale 1ns/1ps

module gpio_bus_tb;

	localparam int n_req = 300;
	localparam int reset_cycles = 8;
	// drive, four waits, drop, seven idle, with room to spare
	localparam int max_req_cycles = 16;
	localparam int max_cycles = reset_cycles + n_req * max_req_cycles + 192;

	logic BUS_agnt_vi;
	logic reset;
	logic req_valid;
	gpio_bus_pkg::bus_req_t req;
	logic req_ready;
	gpio_bus_pkg::bus_rsp_t rsp;
	gpio_bus_pkg::gpio_bank_u gp_op;
	logic [gpio_bus_pkg::gpio_words-1:0] gp_op_valid;
	gpio_bus_pkg::gpio_bank_u gp_ip;

	int cycle_count;
	int tests_run;
	int tests_failed;

	`include "gpio_bus_model.svh"

	gpio_bus_slave dut_i (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset (reset),
		.req_valid (req_valid),
		.req (req),
		.req_ready (req_ready),
		.rsp (rsp),
		.gp_op (gp_op),
		.gp_op_valid (gp_op_valid),
		.gp_ip (gp_ip)
	);

	// 100 ns clock
	always #50 BUS_agnt_vi = ~BUS_agnt_vi;

	// hang guard
	always @(posedge BUS_agnt_vi) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > max_cycles) begin
			$display("timeout after %0d cycles, a request was never answered", max_cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic gpio_bus_pkg::gpio_bank_u random_bank();
		gpio_bus_pkg::gpio_bank_u b;
		for (int i = 0; i < gpio_bus_pkg::gpio_words; i++) begin
			b.words[i] = $urandom;
		end
		return b;
	endfunction

	// random direction, word and address class
	task automatic make_request(output gpio_bus_pkg::bus_req_t r, output string name);
		int unsigned idx;
		int unsigned kind;
		int unsigned sel;
		string kind_name;
		r.rnw = $urandom % 2;
		idx = $urandom % gpio_bus_pkg::gpio_words;
		kind = $urandom % 6;
		sel = $urandom % 3;
		r.write_data = $urandom;
		case (kind)
			0, 1, 2: begin
				r.addr = gpio_bus_pkg::gpo_base + idx * 4;
				kind_name = "gpo";
			end
			3: begin
				r.addr = gpio_bus_pkg::gpi_base + idx * 4;
				kind_name = "gpi";
			end
			4: begin
				kind_name = "outside";
				// just past gpi, just below gpo, or far away
				if (sel == 0)
					r.addr = gpio_bus_pkg::gpi_base + 32'h20 + idx * 4;
				else if (sel == 1)
					r.addr = gpio_bus_pkg::gpo_base - 4 * (idx + 1);
				else
					r.addr = $urandom | 32'h8000_0000;
			end
			default: begin
				kind_name = "unaligned";
				r.addr = (sel[0] ? gpio_bus_pkg::gpi_base : gpio_bus_pkg::gpo_base) +
					idx * 4 + 1 + ($urandom % 3);
			end
		endcase
		name = $sformatf("%s %s %h", r.rnw ? "read" : "write", kind_name, r.addr);
	endtask

	// no ready, no strobe, idle response, pins as modelled
	task automatic check_quiet(input string name);
		gpio_bus_pkg::bus_rsp_t idle_rsp;
		idle_rsp.read_data = model_rd;
		idle_rsp.error = 1'b0;
		checks_run++;
		if (req_ready) begin
			checks_failed++;
			$display("%s: req_ready is high outside the ready cycle of a request", name);
		end
		check_rsp(name, idle_rsp, rsp);
		check_strobe(name, '0, gp_op_valid);
		check_bank(name, model_bank, gp_op);
	endtask

	task automatic report_test(input string name, input int fails_before);
		tests_run++;
		if (checks_failed == fails_before) begin
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: failed", name);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// one request through the handshake
	////////////////////////////////////////////////////////////////////////////

	task automatic run_request(input int n);
		gpio_bus_pkg::bus_req_t r;
		gpio_bus_pkg::bus_rsp_t exp_rsp;
		logic [gpio_bus_pkg::gpio_words-1:0] exp_strobe;
		string name;
		int edges;
		int gap;
		int fails_before;
		make_request(r, name);
		name = $sformatf("req %0d %s", n, name);
		fails_before = checks_failed;
		gap = $urandom % 8;
		@(posedge BUS_agnt_vi);
		req_valid <= 1'b1;
		req <= r;
		// slave is idle here, so the next edge accepts
		edges = 0;
		forever begin
			@(posedge BUS_agnt_vi);
			edges++;
			@(negedge BUS_agnt_vi);
			if (req_ready)
				break;
			check_quiet(name);
		end
		// ready cycle, gp_ip has been stable since valid rose
		predict(r, gp_ip, exp_rsp, exp_strobe);
		check_latency(name, r.rnw ? int'(gpio_bus_pkg::read_waits) :
			int'(gpio_bus_pkg::write_waits), edges);
		check_rsp(name, exp_rsp, rsp);
		check_bank(name, model_bank, gp_op);
		check_strobe(name, exp_strobe, gp_op_valid);
		@(posedge BUS_agnt_vi);
		req_valid <= 1'b0;
		@(negedge BUS_agnt_vi);
		check_quiet(name);
		// idle gap, inputs move only now
		repeat (gap) begin
			@(posedge BUS_agnt_vi);
			gp_ip <= random_bank();
			@(negedge BUS_agnt_vi);
			check_quiet(name);
		end
		report_test(name, fails_before);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int fails_before;
		void'($urandom(47471));
		BUS_agnt_vi = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		gp_ip.flat = '0;
		cycle_count = 0;
		tests_run = 0;
		tests_failed = 0;
		checks_run = 0;
		checks_failed = 0;
		model_bank.flat = '0;
		model_rd = 'x;
		repeat (reset_cycles) @(posedge BUS_agnt_vi);
		reset <= 1'b0;
		@(negedge BUS_agnt_vi);
		// everything low straight out of reset
		fails_before = checks_failed;
		check_quiet("reset state");
		report_test("reset state", fails_before);
		for (int n = 0; n < n_req; n++) begin
			run_request(n);
		end
		$display("tests %0d, tests failed %0d, checks %0d, checks failed %0d",
			tests_run, tests_failed, checks_run, checks_failed);
		if (checks_failed == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule : gpio_bus_tb

//--- verilog/gpio_bus_slave.sv
// top of the gpio bus slave
// bus controller steering the gpo bank beside it,
// gp_op pins from the bank, gp_ip pins into the controller

`timescale 1ns/1ps

module gpio_bus_slave (
	input logic BUS_agnt_vi,
	input logic reset,
	// request channel
	input logic req_valid,
	input gpio_bus_pkg::bus_req_t req,
	output logic req_ready,
	// response, valid with ready
	output gpio_bus_pkg::bus_rsp_t rsp,
	// gpio pins
	output gpio_bus_pkg::gpio_bank_u gp_op,
	output logic [gpio_bus_pkg::gpio_words-1:0] gp_op_valid,
	input gpio_bus_pkg::gpio_bank_u gp_ip
);

	// controller to bank
	gpio_bus_pkg::gpo_wr_t gpo_wr;
	// bank contents, readback and pins
	gpio_bus_pkg::gpio_bank_u gpo_q;

	////////////////////////////////////////////////////////////////////////////
	// bus access controller
	////////////////////////////////////////////////////////////////////////////

	bus_access_ctrl ctrl_i (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset (reset),
		.req_valid (req_valid),
		.req (req),
		.req_ready (req_ready),
		.rsp (rsp),
		.gpo_wr (gpo_wr),
		.gpo_q (gpo_q),
		.gp_ip (gp_ip)
	);

	////////////////////////////////////////////////////////////////////////////
	// gpo register bank
	////////////////////////////////////////////////////////////////////////////

	gpo_reg_bank gpo_i (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset (reset),
		.gpo_wr (gpo_wr),
		.gpo_q (gpo_q),
		.gp_op_valid (gp_op_valid)
	);

	// pins take the flat view
	assign gp_op.flat = gpo_q.flat;

endmodule : gpio_bus_slave

//--- verilog/gpo_reg_bank.sv
// general purpose output bank of eight 32-bit words
// one word written per gpo_wr.en, visible one edge later
// together with a one-cycle strobe for that word

`timescale 1ns/1ps

module gpo_reg_bank (
	input logic BUS_agnt_vi,
	input logic reset,
	input gpio_bus_pkg::gpo_wr_t gpo_wr,
	output gpio_bus_pkg::gpio_bank_u gpo_q,
	output logic [gpio_bus_pkg::gpio_words-1:0] gp_op_valid
);

	// output words, pins come up at zero
	gpio_bus_pkg::gpio_bank_u bank_q;
	// per word strobe
	logic [gpio_bus_pkg::gpio_words-1:0] strobe_q;
	// one hot of the incoming index
	logic [gpio_bus_pkg::gpio_words-1:0] wr_onehot;

	assign wr_onehot = gpio_bus_pkg::gpio_words'(1) << gpo_wr.index;

	////////////////////////////////////////////////////////////////////////////
	// word storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			bank_q.flat <= '0;
		end else if (gpo_wr.en) begin
			// only the indexed word moves
			bank_q.words[gpo_wr.index] <= gpo_wr.data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// write strobes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			strobe_q <= '0;
		end else if (gpo_wr.en) begin
			strobe_q <= wr_onehot;
		end else begin
			// pulse lasts one cycle
			strobe_q <= '0;
		end
	end

	assign gpo_q = bank_q;
	assign gp_op_valid = strobe_q;

	// at most one strobe at a time
	strobe_onehot: assert property (@(posedge BUS_agnt_vi) disable iff (reset)
		$onehot0(gp_op_valid));

endmodule : gpo_reg_bank

//--- verilog/bus_access_ctrl.sv
// bus side of the gpio slave
// accepts one valid/ready request at a time, waits a fixed count,
// decodes the address and answers with ready plus the response
// gpo writes leave here one cycle ahead of ready

`timescale 1ns/1ps

module bus_access_ctrl (
	input logic BUS_agnt_vi,
	input logic reset,
	input logic req_valid,
	input gpio_bus_pkg::bus_req_t req,
	output logic req_ready,
	output gpio_bus_pkg::bus_rsp_t rsp,
	output gpio_bus_pkg::gpo_wr_t gpo_wr,
	input gpio_bus_pkg::gpio_bank_u gpo_q,
	input gpio_bus_pkg::gpio_bank_u gp_ip
);

	// fsm and wait counter
	logic [1:0] state_q;
	logic [gpio_bus_pkg::cnt_w-1:0] cnt_q;
	logic [gpio_bus_pkg::cnt_w-1:0] waits;
	logic last_wait;

	// request held from acceptance on
	gpio_bus_pkg::bus_req_t req_q;

	// decode of the held request
	logic in_gpo;
	logic in_gpi;
	logic unaligned;
	logic err;
	logic [gpio_bus_pkg::word_idx_w-1:0] idx;
	logic [gpio_bus_pkg::data_w-1:0] rd_word;

	// registered response
	logic ready_q;
	logic rsp_error_q;
	logic [gpio_bus_pkg::data_w-1:0] rsp_data_q;

	////////////////////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////////////////////

	// upper bits pick the range, index below, byte offset at the bottom
	assign in_gpo = req_q.addr[gpio_bus_pkg::addr_w-1:gpio_bus_pkg::range_lsb] ==
		gpio_bus_pkg::gpo_base[gpio_bus_pkg::addr_w-1:gpio_bus_pkg::range_lsb];
	assign in_gpi = req_q.addr[gpio_bus_pkg::addr_w-1:gpio_bus_pkg::range_lsb] ==
		gpio_bus_pkg::gpi_base[gpio_bus_pkg::addr_w-1:gpio_bus_pkg::range_lsb];
	assign unaligned = |req_q.addr[gpio_bus_pkg::idx_lsb-1:0];
	assign idx = req_q.addr[gpio_bus_pkg::range_lsb-1:gpio_bus_pkg::idx_lsb];

	// outside map, bad alignment, or a write into read-only gpi
	assign err = !(in_gpo || in_gpi) || unaligned || (in_gpi && !req_q.rnw);

	// readback word, gpo bank or input pins
	assign rd_word = in_gpi ? gp_ip.words[idx] : gpo_q.words[idx];

	////////////////////////////////////////////////////////////////////////////
	// handshake and wait states
	////////////////////////////////////////////////////////////////////////////

	assign waits = req_q.rnw ? gpio_bus_pkg::read_waits : gpio_bus_pkg::write_waits;
	// edge that completes the wait count is the next one
	assign last_wait = (state_q == gpio_bus_pkg::st_wait) &&
		(cnt_q == waits - gpio_bus_pkg::cnt_w'(1));

	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			state_q <= gpio_bus_pkg::st_idle;
			cnt_q <= '0;
			ready_q <= 1'b0;
			rsp_error_q <= 1'b0;
		end else begin
			// ready and error live for one cycle
			ready_q <= 1'b0;
			rsp_error_q <= 1'b0;
			case (state_q)
				gpio_bus_pkg::st_idle: begin
					if (req_valid) begin
						// acceptance edge is edge one
						state_q <= gpio_bus_pkg::st_wait;
						cnt_q <= gpio_bus_pkg::cnt_w'(1);
					end
				end
				gpio_bus_pkg::st_wait: begin
					if (last_wait) begin
						state_q <= gpio_bus_pkg::st_done;
						cnt_q <= '0;
						ready_q <= 1'b1;
						rsp_error_q <= err;
					end else begin
						cnt_q <= cnt_q + gpio_bus_pkg::cnt_w'(1);
					end
				end
				gpio_bus_pkg::st_done: begin
					// wait for requester to drop valid
					if (!req_valid) begin
						state_q <= gpio_bus_pkg::st_idle;
					end
				end
				default: begin
					state_q <= gpio_bus_pkg::st_idle;
					cnt_q <= '0;
				end
			endcase
		end
	end

	// request capture and read data
	always_ff @(posedge BUS_agnt_vi) begin
		if (state_q == gpio_bus_pkg::st_idle && req_valid) begin
			req_q <= req;
		end
		// good reads only, otherwise the last data stays
		if (last_wait && req_q.rnw && !err) begin
			rsp_data_q <= rd_word;
		end
	end

	assign req_ready = ready_q;
	assign rsp = '{read_data: rsp_data_q, error: rsp_error_q};

	////////////////////////////////////////////////////////////////////////////
	// gpo write, one cycle before ready
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		gpo_wr.en = last_wait && !req_q.rnw && !err;
		gpo_wr.index = idx;
		gpo_wr.data = req_q.write_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// one ready pulse per request
	ready_single: assert property (@(posedge BUS_agnt_vi) disable iff (reset)
		req_ready |=> !req_ready);

	// bank write only for a held write request, and ready follows
	gpo_wr_is_write: assert property (@(posedge BUS_agnt_vi) disable iff (reset)
		gpo_wr.en |-> (req_valid && !req.rnw) ##1 req_ready);

	// held request is frozen while counting
	req_held: assert property (@(posedge BUS_agnt_vi) disable iff (reset)
		state_q == gpio_bus_pkg::st_wait |=> $stable(req_q));

endmodule : bus_access_ctrl

//--- verilog/gpio_bus_pkg.sv
// shared definitions for the gpio bus slave
// address map, wait counts, bus request and response structs,
// the gpo write struct and the 256-bit bank union
// files refer to these by scoped names

package gpio_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bus widths and bank geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int data_w = 32;
	localparam int addr_w = 32;

	// words per bank, and bits to pick one
	localparam int gpio_words = 8;
	localparam int word_idx_w = 3;

	// byte offset bits below the word index
	localparam int idx_lsb = 2;
	// first address bit above one bank range
	localparam int range_lsb = idx_lsb + word_idx_w;

	////////////////////////////////////////////////////////////////////////////
	// address map
	////////////////////////////////////////////////////////////////////////////

	// gpo words, read and write
	localparam logic [addr_w-1:0] gpo_base = 32'h0100_0000;
	// gpi words, read only
	localparam logic [addr_w-1:0] gpi_base = 32'h0100_0020;

	////////////////////////////////////////////////////////////////////////////
	// wait states and controller encodings
	////////////////////////////////////////////////////////////////////////////

	// wait counter width, big enough for read_waits
	localparam int cnt_w = 3;

	// edges from acceptance to ready, acceptance counted
	localparam logic [cnt_w-1:0] write_waits = 3'd3;
	localparam logic [cnt_w-1:0] read_waits = 3'd4;

	// controller states
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_wait = 2'd1;
	localparam logic [1:0] st_done = 2'd2;

	////////////////////////////////////////////////////////////////////////////
	// bus and bank types
	////////////////////////////////////////////////////////////////////////////

	// request as held by the requester until ready
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] write_data;
		logic rnw;
	} bus_req_t;

	// response, valid in the ready cycle only
	typedef struct packed {
		logic [data_w-1:0] read_data;
		logic error;
	} bus_rsp_t;

	// single word write into the output bank
	typedef struct packed {
		logic en;
		logic [word_idx_w-1:0] index;
		logic [data_w-1:0] data;
	} gpo_wr_t;

	// 256 gpio bits, flat for the pins or as eight words
	typedef union packed {
		logic [gpio_words*data_w-1:0] flat;
		logic [gpio_words-1:0][data_w-1:0] words;
	} gpio_bank_u;

endpackage : gpio_bus_pkg
